//--- Makefile
# Verilator build for the pulse APU testbench

VERILATOR ?= verilator
TOP       ?= apuTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- hw/apuPkg.sv
// --------------------
// APU shared types
// --------------------
`default_nettype none

package apuPkg;

  localparam int periodWidth = 11;
  localparam int sampleWidth = 4;

  // Frame sequencer step counts
  localparam logic [15:0] frameStepCycles [5] = '{
    16'd7457,
    16'd14913,
    16'd22371,
    16'd29829,
    16'd37281  // 5-step only
  };

  // $4000/$4004 layout
  typedef struct packed {
    logic [1:0] duty;
    logic       loopHalt;  // Envelope loop, also length halt
    logic       constVol;
    logic [3:0] volume;
  } envCtl_t;

  // $4001/$4005 layout
  typedef struct packed {
    logic       enable;
    logic [2:0] divPeriod;
    logic       negate;
    logic [2:0] shift;
  } sweepCtl_t;

  // Same write byte, meaning depends on the register
  typedef union packed {
    envCtl_t   env;
    sweepCtl_t sweep;
  } regByte_t;

  typedef struct packed {
    logic quarterFrame;  // Envelope clock
    logic halfFrame;     // Length and sweep clock
  } frameStrobes_t;

  typedef struct packed {
    logic       we;
    logic [1:0] regSel;
    regByte_t   data;
  } chanWrite_t;

  // Length load values, always even
  function automatic logic [7:0] lengthTable(input logic [4:0] index);
    logic [6:0] entry;
    case (index)
      5'd0:  entry = 7'h05;
      5'd1:  entry = 7'h7F;
      5'd2:  entry = 7'h0A;
      5'd3:  entry = 7'h01;
      5'd4:  entry = 7'h14;
      5'd5:  entry = 7'h02;
      5'd6:  entry = 7'h28;
      5'd7:  entry = 7'h03;
      5'd8:  entry = 7'h50;
      5'd9:  entry = 7'h04;
      5'd10: entry = 7'h1E;
      5'd11: entry = 7'h05;
      5'd12: entry = 7'h07;
      5'd13: entry = 7'h06;
      5'd14: entry = 7'h0D;
      5'd15: entry = 7'h07;
      5'd16: entry = 7'h06;
      5'd17: entry = 7'h08;
      5'd18: entry = 7'h0C;
      5'd19: entry = 7'h09;
      5'd20: entry = 7'h18;
      5'd21: entry = 7'h0A;
      5'd22: entry = 7'h30;
      5'd23: entry = 7'h0B;
      5'd24: entry = 7'h60;
      5'd25: entry = 7'h0C;
      5'd26: entry = 7'h24;
      5'd27: entry = 7'h0D;
      5'd28: entry = 7'h08;
      5'd29: entry = 7'h0E;
      5'd30: entry = 7'h10;
      5'd31: entry = 7'h0F;
    endcase
    return {entry, 1'b0};
  endfunction

endpackage

`default_nettype wire

//--- hw/apuTop.sv
// --------------------
// Pulse APU top
// --------------------
`timescale 1ns/1ps
`default_nettype none

module apuTop (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         ce,
  input  logic [4:0]                   addr,
  input  logic [7:0]                   din,
  input  logic                         mw,
  input  logic                         mr,
  output logic [7:0]                   dout,
  output logic                         irq,
  output logic [apuPkg::sampleWidth:0] sample
);
  import apuPkg::*;

  chanWrite_t             chanWr [2];
  frameStrobes_t          strobes;
  logic [sampleWidth-1:0] chanSample [2];
  logic [1:0]             chanNonZero;
  logic [1:0]             enabled;      // Square 2, square 1
  logic [1:0]             enableNext;   // Includes a $15 write in this cycle
  logic                   frameWrite;
  logic                   statusRead;
  logic                   frameIrq;

  // --------------------
  // Register decode
  // --------------------
  assign frameWrite = mw && (addr == 5'h17);
  assign statusRead = mr && (addr == 5'h15);  // Clears frame flag
  assign enableNext = (mw && addr == 5'h15) ? din[1:0] : enabled;

  always_ff @(posedge clk) begin
    if (reset) begin
      enabled <= 2'b00;
    end else if (ce) begin
      enabled <= enableNext;
    end
  end

  frameSequencer frameSeq (
    .clk        (clk),
    .reset      (reset),
    .ce         (ce),
    .frameWrite (frameWrite),
    .din        (din),
    .statusRead (statusRead),
    .strobes    (strobes),
    .frameIrq   (frameIrq)
  );

  // --------------------
  // Square channels
  // --------------------
  for (genvar ch = 0; ch < 2; ch++) begin : gSquare
    // $00-$03 and $04-$07
    assign chanWr[ch].we     = mw && (addr[4:2] == 3'(ch));
    assign chanWr[ch].regSel = addr[1:0];
    assign chanWr[ch].data   = din;

    squareChannel #(
      .isSecond (1'(ch))
    ) square (
      .clk     (clk),
      .reset   (reset),
      .ce      (ce),
      .wr      (chanWr[ch]),
      .strobes (strobes),
      .enabled (enableNext[ch]),
      .sample  (chanSample[ch]),
      .nonZero (chanNonZero[ch])
    );
  end

  // Bit 6 is the visible frame IRQ
  assign dout = {1'b0, frameIrq, 4'b0000, chanNonZero};
  assign irq  = frameIrq;

  // Plain sum, no mixer curve
  assign sample = {1'b0, chanSample[0]} + {1'b0, chanSample[1]};

endmodule

`default_nettype wire

//--- hw/envelopeUnit.sv
// --------------------
// Envelope FSM
// --------------------
`timescale 1ns/1ps
`default_nettype none

module envelopeUnit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ce,
  input  logic                           quarterFrame,
  input  logic                           restart,
  input  apuPkg::envCtl_t                ctl,
  output logic [apuPkg::sampleWidth-1:0] volume
);
  import apuPkg::*;

  typedef enum logic [1:0] {
    envRestart,  // Start flag pending
    envDivide,
    envDecay     // Divider expired, step the level
  } envState_t;

  envState_t              state;
  logic [3:0]             divider;
  logic [sampleWidth-1:0] level;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= envDivide;
      divider <= 4'd0;
      level   <= '0;
    end else if (ce) begin
      case (state)
        envRestart: begin
          if (quarterFrame) begin
            level   <= '1;
            divider <= ctl.volume;
            state   <= envDivide;
          end
        end
        envDivide: begin
          if (quarterFrame) begin
            if (divider == 4'd0) begin
              divider <= ctl.volume;
              state   <= envDecay;
            end else begin
              divider <= divider - 4'd1;
            end
          end
        end
        envDecay: begin
          if (level != '0 || ctl.loopHalt)
            level <= level - 1'b1;  // Wraps 0 -> 15 when looping
          state <= envDivide;
        end
        default: state <= envDivide;
      endcase
      if (restart)
        state <= envRestart;
    end
  end

  assign volume = ctl.constVol ? ctl.volume : level;

endmodule

`default_nettype wire

//--- hw/frameSequencer.sv
// --------------------
// Frame sequencer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ce,
  input  logic                  frameWrite,
  input  logic [7:0]            din,
  input  logic                  statusRead,
  output apuPkg::frameStrobes_t strobes,
  output logic                  frameIrq
);
  import apuPkg::*;

  logic [15:0] cycleCount;
  logic        fiveStep;      // Mode bit from $17
  logic        irqInhibit;
  logic        oddCycle;      // Even/odd toggle
  logic        writePending;  // $17 write landed on an odd cycle
  logic        frameFlag;
  logic [1:0]  irqStretch;    // Keeps the flag set two more cycles

  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCount   <= 16'd4;
      fiveStep     <= 1'b0;
      irqInhibit   <= 1'b0;
      oddCycle     <= 1'b0;
      writePending <= 1'b0;
      frameFlag    <= 1'b0;
      irqStretch   <= 2'b00;
      strobes      <= '0;
    end else if (ce) begin
      oddCycle   <= !oddCycle;
      cycleCount <= cycleCount + 16'd1;
      irqStretch <= {irqStretch[0], 1'b0};
      strobes    <= '0;  // Single-cycle pulses

      // A set in progress beats any clear
      if (irqStretch[1])
        frameFlag <= 1'b1;
      else if (statusRead || (frameWrite && din[6]))
        frameFlag <= 1'b0;

      // --------------------
      // Step decode
      // --------------------
      if (cycleCount == frameStepCycles[0]) begin
        strobes.quarterFrame <= 1'b1;
      end else if (cycleCount == frameStepCycles[1]) begin
        strobes.quarterFrame <= 1'b1;
        strobes.halfFrame    <= 1'b1;
      end else if (cycleCount == frameStepCycles[2]) begin
        strobes.quarterFrame <= 1'b1;
      end else if (cycleCount == frameStepCycles[3]) begin
        if (!fiveStep) begin
          strobes.quarterFrame <= 1'b1;
          strobes.halfFrame    <= 1'b1;
          cycleCount           <= 16'd0;
          irqStretch           <= 2'b11;
          frameFlag            <= 1'b1;
        end
      end else if (cycleCount == frameStepCycles[4]) begin
        strobes.quarterFrame <= 1'b1;  // End of the 5-step frame
        strobes.halfFrame    <= 1'b1;
        cycleCount           <= 16'd0;
      end

      // Delayed half of an odd-cycle $17 write
      writePending <= 1'b0;
      if (writePending) begin
        if (fiveStep) begin
          strobes.quarterFrame <= 1'b1;
          strobes.halfFrame    <= 1'b1;
        end
        cycleCount <= 16'd0;
      end

      if (frameWrite) begin
        fiveStep   <= din[7];
        irqInhibit <= din[6];
        if (!oddCycle) begin
          if (din[7]) begin
            strobes.quarterFrame <= 1'b1;
            strobes.halfFrame    <= 1'b1;
          end
          cycleCount <= 16'd0;
        end
        writePending <= oddCycle;
      end
    end
  end

  assign frameIrq = frameFlag && !irqInhibit;

endmodule

`default_nettype wire

//--- hw/lengthCounter.sv
// --------------------
// Length counter
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lengthCounter (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic       halfFrame,
  input  logic       load,     // Register 3 write
  input  logic [4:0] index,
  input  logic       halt,
  input  logic       enabled,  // From $15
  output logic       nonZero,
  output logic       zero
);
  import apuPkg::*;

  logic [7:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 8'd0;
    end else if (ce) begin
      if (load)
        count <= lengthTable(index);
      if (halfFrame && count != 8'd0 && !halt)
        count <= count - 8'd1;
      // Disabled channel holds zero
      if (!enabled)
        count <= 8'd0;
    end
  end

  assign nonZero = (count != 8'd0);
  assign zero    = !nonZero;

endmodule

`default_nettype wire

//--- hw/squareChannel.sv
// --------------------
// Square channel
// --------------------
`timescale 1ns/1ps
`default_nettype none

module squareChannel #(
  parameter bit isSecond = 1'b0
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ce,
  input  apuPkg::chanWrite_t             wr,
  input  apuPkg::frameStrobes_t          strobes,
  input  logic                           enabled,
  output logic [apuPkg::sampleWidth-1:0] sample,
  output logic                           nonZero
);
  import apuPkg::*;

  envCtl_t                envCtl;
  logic [periodWidth-1:0] period;
  logic [periodWidth:0]   timerCount;
  logic [2:0]             seqPos;
  logic [7:0]             rawData;
  logic                   restart;
  logic                   sweepWrite;
  logic [periodWidth-1:0] sweepPeriod;
  logic                   sweepUpdate;
  logic                   sweepMute;
  logic [sampleWidth-1:0] envVolume;
  logic                   lengthZero;
  logic [7:0]             dutyPattern;

  assign rawData    = wr.data;
  assign restart    = wr.we && (wr.regSel == 2'd3);
  assign sweepWrite = wr.we && (wr.regSel == 2'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      envCtl     <= '0;
      period     <= '0;
      timerCount <= '0;
      seqPos     <= 3'd0;
    end else if (ce) begin
      if (wr.we) begin
        case (wr.regSel)
          2'd0:    envCtl <= wr.data.env;
          2'd2:    period[7:0] <= rawData;
          2'd3:    period[10:8] <= rawData[2:0];  // Index goes to the length counter
          default: ;
        endcase
      end
      if (sweepUpdate)
        period <= sweepPeriod;

      // One sequencer step every 2*(P+1) cycles
      if (timerCount == '0) begin
        timerCount <= {period, 1'b1};
        seqPos     <= seqPos - 3'd1;
      end else begin
        timerCount <= timerCount - 1'b1;
      end
      if (restart)
        seqPos <= 3'd0;
    end
  end

  envelopeUnit envelope (
    .clk          (clk),
    .reset        (reset),
    .ce           (ce),
    .quarterFrame (strobes.quarterFrame),
    .restart      (restart),
    .ctl          (envCtl),
    .volume       (envVolume)
  );

  sweepUnit #(
    .isSecond (isSecond)
  ) sweep (
    .clk          (clk),
    .reset        (reset),
    .ce           (ce),
    .halfFrame    (strobes.halfFrame),
    .ctlWrite     (sweepWrite),
    .ctl          (wr.data.sweep),
    .period       (period),
    .newPeriod    (sweepPeriod),
    .periodUpdate (sweepUpdate),
    .mute         (sweepMute)
  );

  lengthCounter length (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .halfFrame (strobes.halfFrame),
    .load      (restart),
    .index     (rawData[7:3]),
    .halt      (envCtl.loopHalt),
    .enabled   (enabled),
    .nonZero   (nonZero),
    .zero      (lengthZero)
  );

  // Output gating
  always_comb begin
    case (envCtl.duty)
      2'd0:    dutyPattern = 8'b1000_0000;  // 12.5%
      2'd1:    dutyPattern = 8'b1100_0000;
      2'd2:    dutyPattern = 8'b1111_0000;
      default: dutyPattern = 8'b0011_1111;  // 25% inverted
    endcase
    if (lengthZero || sweepMute || !dutyPattern[seqPos])
      sample = '0;
    else
      sample = envVolume;
  end

endmodule

`default_nettype wire

//--- hw/sweepUnit.sv
// --------------------
// Sweep unit
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sweepUnit #(
  parameter bit isSecond = 1'b0
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ce,
  input  logic                           halfFrame,
  input  logic                           ctlWrite,
  input  apuPkg::sweepCtl_t              ctl,
  input  logic [apuPkg::periodWidth-1:0] period,
  output logic [apuPkg::periodWidth-1:0] newPeriod,
  output logic                           periodUpdate,
  output logic                           mute
);
  import apuPkg::*;

  sweepCtl_t              ctlReg;
  logic [2:0]             divider;
  logic                   reloadFlag;   // Set by a control write
  logic [periodWidth-1:0] shifted;
  logic [periodWidth-1:0] delta;
  logic [periodWidth:0]   target;       // One extra bit for overflow

  // Target period
  assign shifted = period >> ctlReg.shift;
  // Square 1 negates with ones complement, square 2 with twos complement
  assign delta   = ctlReg.negate ? (~shifted + {{(periodWidth-1){1'b0}}, isSecond}) : shifted;
  assign target  = {1'b0, period} + {1'b0, delta};

  assign newPeriod = target[periodWidth-1:0];
  assign mute      = (period < periodWidth'(8)) || (!ctlReg.negate && target[periodWidth]);

  assign periodUpdate = halfFrame && (divider == 3'd0) && ctlReg.enable &&
                        (ctlReg.shift != 3'd0) && !mute;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctlReg     <= '0;
      divider    <= 3'd0;
      reloadFlag <= 1'b0;
    end else if (ce) begin
      if (halfFrame) begin
        if (divider == 3'd0 || reloadFlag)
          divider <= ctlReg.divPeriod;
        else
          divider <= divider - 3'd1;
        reloadFlag <= 1'b0;
      end
      // A write in the same cycle keeps its reload for the next half frame
      if (ctlWrite) begin
        ctlReg     <= ctl;
        reloadFlag <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
hw/apuPkg.sv
hw/envelopeUnit.sv
hw/sweepUnit.sv
hw/lengthCounter.sv
hw/squareChannel.sv
hw/frameSequencer.sv
hw/apuTop.sv
verification/tbClock.sv
verification/apuTb.sv

//--- verification/apuTb.sv
// --------------------
// Pulse APU testbench
// --------------------
`timescale 1ns/1ps
`default_nettype none

module apuTb;

  localparam int frameCycles   = 37281;  // Longest frame, 5-step mode
  localparam int timeoutCycles = 6 * frameCycles * 11 / 10;
  localparam int randomSeed    = 94400;

  // Length load values for the 32 indices
  localparam int lengthValues [32] = '{
    10, 254, 20,  2, 40,  4, 80,  6, 160,  8, 60, 10, 14, 12, 26, 14,
    12,  16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30
  };

  logic                         clk;
  logic                         reset;
  logic                         ce;
  logic [4:0]                   addr;
  logic [7:0]                   din;
  logic                         mw;
  logic                         mr;
  logic [7:0]                   dout;
  logic                         irq;
  logic [apuPkg::sampleWidth:0] sample;

  int lenModel [2];     // Model length counts of square 1 and square 2
  bit flagModel;        // Visible frame IRQ
  bit modelValid;       // Compare process active
  int cycleCount = 0;

  tbClock #(.periodNs(100)) clockGen (.clk(clk));

  apuTop DUT (
    .clk    (clk),
    .reset  (reset),
    .ce     (ce),
    .addr   (addr),
    .din    (din),
    .mw     (mw),
    .mr     (mr),
    .dout   (dout),
    .irq    (irq),
    .sample (sample)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic int expectedLength(input int index);
    return lengthValues[index];
  endfunction

  function automatic logic [7:0] referenceStatus(input int len0, input int len1, input bit flag);
    return {1'b0, flag, 4'b0000, len1 != 0, len0 != 0};
  endfunction

  // Rebuilds the sum from per-channel volumes (v1 below 8 and v2 from 8 up)
  function automatic int expectedMix(input int observed, input int v1, input int v2);
    bit high1;
    bit high2;
    high2 = (observed >= v2);
    high1 = ((observed - (high2 ? v2 : 0)) != 0);
    return (high1 ? v1 : 0) + (high2 ? v2 : 0);
  endfunction

  // --------------------
  // Checks and stimulus
  // --------------------
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input int actual, input int expected);
    if (actual !== expected)
      failRun($sformatf("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, actual, expected));
  endtask

  // Starts on a falling edge so the DUT captures on the next rising edge
  task automatic writeReg(input logic [4:0] a, input logic [7:0] d);
    addr = a;
    din  = d;
    mw   = 1'b1;
    @(negedge clk);
    mw   = 1'b0;
  endtask

  task automatic readStatus(output logic [7:0] status);
    addr   = 5'h15;
    mr     = 1'b1;
    status = dout;  // Settled since the last rising edge
    @(negedge clk);
    mr     = 1'b0;
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Finds three rising edges of sample and checks both spacings of 16*(P+1)
  task automatic measureTone(input int period, input int volume);
    int                           edgeAt [3];
    int                           found;
    int                           elapsed;
    int                           limit;
    logic [apuPkg::sampleWidth:0] prev;
    found   = 0;
    elapsed = 0;
    limit   = 3 * 16 * (period + 1) + 5000;
    prev    = sample;
    while (found < 3 && elapsed < limit) begin
      @(negedge clk);
      elapsed++;
      checkValue("sample", int'(sample), (sample == 0) ? 0 : volume);
      if (prev == 0 && sample != 0) begin
        edgeAt[found] = elapsed;
        found++;
      end
      prev = sample;
    end
    if (found < 3) begin
      failRun($sformatf("Tone had only %0d rising edges in %0d cycles", found, limit));
    end else begin
      checkValue("sample edge spacing", edgeAt[1] - edgeAt[0], 16 * (period + 1));
      checkValue("sample edge spacing", edgeAt[2] - edgeAt[1], 16 * (period + 1));
    end
  endtask

  // Status and irq against the model on every rising edge
  always @(posedge clk) begin
    if (modelValid) begin
      checkValue("dout", int'(dout), int'(referenceStatus(lenModel[0], lenModel[1], flagModel)));
      checkValue("irq", int'(irq), int'(flagModel));
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutCycles)
      failRun($sformatf("Timeout after %0d cycles, the tests did not finish", timeoutCycles));
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [7:0] status;
    int         idx0;
    int         idx1;
    int         volume;
    int         period;
    int         v1;
    int         v2;
    int         waited;
    int         bothSeen;
    void'($urandom(randomSeed));
    reset       = 1'b1;
    ce          = 1'b1;
    addr        = 5'h00;
    din         = 8'h00;
    mw          = 1'b0;
    mr          = 1'b0;
    lenModel[0] = 0;
    lenModel[1] = 0;
    flagModel   = 1'b0;
    modelValid  = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    checkValue("dout", int'(dout), 0);
    checkValue("irq", int'(irq), 0);
    checkValue("sample", int'(sample), 0);
    modelValid = 1'b1;

    // Length load and clear by the enable register
    idx0 = $urandom % 32;
    idx1 = $urandom % 32;
    writeReg(5'h15, 8'h03);
    writeReg(5'h03, {5'(idx0), 3'b000});
    lenModel[0] = expectedLength(idx0);
    writeReg(5'h07, {5'(idx1), 3'b000});
    lenModel[1] = expectedLength(idx1);
    readStatus(status);
    checkValue("dout[1:0]", int'(status[1:0]), 3);
    writeReg(5'h15, 8'h00);
    lenModel[0] = 0;
    lenModel[1] = 0;
    waitCycles(1);

    // Countdown from index 3 with halt clear
    writeReg(5'h15, 8'h01);
    writeReg(5'h00, 8'h00);
    writeReg(5'h17, 8'h40);  // 4-step with IRQ inhibited
    writeReg(5'h03, 8'h18);
    lenModel[0] = expectedLength(3);
    waitCycles(20000);
    readStatus(status);
    checkValue("dout[0]", int'(status[0]), 1);
    modelValid = 1'b0;       // Second half frame falls in here
    waitCycles(12000);
    lenModel[0] = 0;
    modelValid  = 1'b1;
    readStatus(status);
    checkValue("dout[0]", int'(status[0]), 0);

    // Same load with halt set
    writeReg(5'h00, 8'h20);
    writeReg(5'h17, 8'h40);
    writeReg(5'h03, 8'h18);
    lenModel[0] = expectedLength(3);
    waitCycles(32000);
    readStatus(status);
    checkValue("dout[0]", int'(status[0]), 1);
    writeReg(5'h15, 8'h00);
    lenModel[0] = 0;

    // Frame IRQ in 4-step mode
    writeReg(5'h17, 8'h40);  // Clears the flag left by the inhibited frames
    writeReg(5'h17, 8'h00);
    modelValid = 1'b0;
    waited     = 0;
    while (!irq && waited < 30000) begin
      @(negedge clk);
      waited++;
    end
    if (!irq)
      failRun("Frame IRQ did not rise within 30000 cycles of the $17 write");
    flagModel  = 1'b1;
    modelValid = 1'b1;
    waitCycles(4);           // Past the two-cycle hold on the flag
    readStatus(status);
    checkValue("dout", int'(status), int'(referenceStatus(0, 0, 1'b1)));
    checkValue("irq", int'(irq), 0);
    flagModel = 1'b0;

    // No IRQ in 5-step mode or with inhibit set
    writeReg(5'h17, 8'h80);
    waitCycles(frameCycles + 10);
    writeReg(5'h17, 8'h40);
    waitCycles(frameCycles + 10);

    // Tone on square 1
    volume = 1 + $urandom % 15;
    period = 8 + $urandom % (32'h3FF - 8 + 1);
    writeReg(5'h15, 8'h01);
    writeReg(5'h00, 8'hB0 | 8'(volume));  // Duty 2, halt, constant volume
    writeReg(5'h02, period[7:0]);
    writeReg(5'h03, {5'd31, period[10:8]});
    lenModel[0] = expectedLength(31);
    measureTone(period, volume);

    // Sweep overflow mutes square 1
    writeReg(5'h01, 8'h81);  // Enabled, add, shift 1
    writeReg(5'h02, 8'h00);
    writeReg(5'h03, {5'd31, 3'b110});
    lenModel[0] = expectedLength(31);
    repeat (6000) begin
      @(negedge clk);
      checkValue("sample", int'(sample), 0);
    end

    // Both squares audible
    v1 = 1 + $urandom % 7;
    v2 = 8 + $urandom % 8;
    writeReg(5'h01, 8'h00);
    writeReg(5'h15, 8'h03);
    writeReg(5'h00, 8'hB0 | 8'(v1));
    writeReg(5'h02, 8'd8);
    writeReg(5'h03, {5'd31, 3'b000});
    lenModel[0] = expectedLength(31);
    writeReg(5'h04, 8'hB0 | 8'(v2));
    writeReg(5'h06, 8'd11);
    writeReg(5'h07, {5'd31, 3'b000});
    lenModel[1] = expectedLength(31);
    bothSeen = 0;
    repeat (2000) begin
      @(negedge clk);
      checkValue("sample", int'(sample), expectedMix(int'(sample), v1, v2));
      if (sample == v1 + v2)
        bothSeen++;
    end
    if (bothSeen == 0) begin
      failRun("The two squares were never high together, no sum was seen");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verification/tbClock.sv
// --------------------
// Testbench clock
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int periodNs = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = !clk;
  end

endmodule

`default_nettype wire
